// File: hdl/mem_pkg.sv
// ##############################
// Byte addresses are relative to the RAM base and are 16 bits wide
// Loads zero-extend; there is no sign extension and no misalignment trap
// ##############################
`default_nettype none

package mem_pkg;

    // ##############################
    // Sizes
    // ##############################
    localparam int BYTE_ADDR_W = 16;
    localparam int DATA_W      = 64;
    localparam int LANES       = DATA_W / 8;              // Byte lanes per word
    localparam int LANE_OFF_W  = 3;
    localparam int WORD_ADDR_W = BYTE_ADDR_W - LANE_OFF_W;
    localparam int RAM_WORDS   = 2 ** WORD_ADDR_W;        // 8192 words of 64 bits

    typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;
    typedef logic [DATA_W-1:0]      data_t;
    typedef logic [LANES-1:0]       byte_mask_t;
    typedef logic [LANE_OFF_W-1:0]  lane_off_t;

    typedef enum logic [1:0] {
        width_8  = 2'b00,
        width_16 = 2'b01,
        width_32 = 2'b10,
        width_64 = 2'b11
    } width_e;

    typedef enum logic {
        peer_cpu = 1'b0,
        peer_dma = 1'b1
    } peer_e;

    // The address bits below the access width are dropped for natural alignment
    function automatic lane_off_t align_offset(input width_e width, input byte_addr_t addr);
        case (width)
            width_8:  return addr[2:0];
            width_16: return {addr[2:1], 1'b0};
            width_32: return {addr[2], 2'b00};
            default:  return 3'b000;                      // Double words start at lane 0
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hdl/mem_ifs.sv
// ##############################
// Requester bus allows one request outstanding per peer, with no back-pressure
// ##############################
`timescale 1ns/100ps
`default_nettype none

// ##############################
// Requester bus
// ##############################
interface mem_port_if import mem_pkg::*; ();

    logic       req;      // Single-cycle request strobe
    logic       we;
    width_e     width;
    byte_addr_t addr;
    data_t      wdata;
    logic       rsp;      // One strobe per request
    data_t      rdata;    // Zero for a write response

    modport requester (
        output req, we, width, addr, wdata,
        input  rsp, rdata
    );

    modport target (
        input  req, we, width, addr, wdata,
        output rsp, rdata
    );

endinterface

// ##############################
// RAM-side bus
// ##############################
interface ram_if import mem_pkg::*; ();

    logic       en;
    logic       we;
    word_addr_t word_addr;
    byte_mask_t byte_mask;    // One enable per byte lane
    data_t      wdata;        // Already shifted onto its lanes
    data_t      rdata;        // Registered read word

    modport master (
        output en, we, word_addr, byte_mask, wdata
    );

    modport slave (
        input  en, we, word_addr, byte_mask, wdata,
        output rdata
    );

    modport reader (
        input rdata
    );

endinterface

`default_nettype wire

// File: hdl/mem_arbiter.sv
// ##############################
// One pending slot per peer absorbs a lost contest; a peer must wait for its rsp
// ##############################
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter import mem_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    mem_port_if.target cpu,
    mem_port_if.target dma,
    output logic       issue,
    output logic       issue_we,
    output width_e     issue_width,
    output byte_addr_t issue_addr,
    output data_t      issue_wdata,
    output peer_e      issue_peer,
    input  logic       done,
    input  peer_e      done_peer,
    input  data_t      done_data
);

    logic [1:0] live_req;
    logic       live_we    [2];
    width_e     live_width [2];
    byte_addr_t live_addr  [2];
    data_t      live_wdata [2];

    logic [1:0] pend_valid;
    logic       pend_we    [2];
    width_e     pend_width [2];
    byte_addr_t pend_addr  [2];
    data_t      pend_wdata [2];

    logic [1:0] cand_valid;
    peer_e      grant;
    peer_e      prio;                                     // Winner of the next contest

    // ##############################
    // Candidate selection
    // ##############################
    always_comb begin
        live_req[peer_cpu]   = cpu.req;
        live_we[peer_cpu]    = cpu.we;
        live_width[peer_cpu] = cpu.width;
        live_addr[peer_cpu]  = cpu.addr;
        live_wdata[peer_cpu] = cpu.wdata;
        live_req[peer_dma]   = dma.req;
        live_we[peer_dma]    = dma.we;
        live_width[peer_dma] = dma.width;
        live_addr[peer_dma]  = dma.addr;
        live_wdata[peer_dma] = dma.wdata;
    end

    assign cand_valid = pend_valid | live_req;           // A held request never overlaps a new one

    always_comb begin
        if (&cand_valid) begin
            grant = prio;
        end else if (cand_valid[peer_dma]) begin
            grant = peer_dma;
        end else begin
            grant = peer_cpu;
        end
    end

    assign issue       = |cand_valid;
    assign issue_peer  = grant;
    assign issue_we    = pend_valid[grant] ? pend_we[grant]    : live_we[grant];
    assign issue_width = pend_valid[grant] ? pend_width[grant] : live_width[grant];
    assign issue_addr  = pend_valid[grant] ? pend_addr[grant]  : live_addr[grant];
    assign issue_wdata = pend_valid[grant] ? pend_wdata[grant] : live_wdata[grant];

    // ##############################
    // Pending slots and priority
    // ##############################
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 2'b00;
            prio       <= peer_cpu;
        end else begin
            for (int p = 0; p < 2; p++) begin
                pend_valid[p] <= cand_valid[p] && (grant != peer_e'(p));  // Loser waits
            end
            if (&cand_valid) begin
                prio <= (grant == peer_cpu) ? peer_dma : peer_cpu;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (live_req[p] && (grant != peer_e'(p))) begin
                pend_we[p]    <= live_we[p];
                pend_width[p] <= live_width[p];
                pend_addr[p]  <= live_addr[p];
                pend_wdata[p] <= live_wdata[p];
            end
        end
    end

    // Response goes back only to the owner of the access
    assign cpu.rsp   = done && (done_peer == peer_cpu);
    assign cpu.rdata = done_data;
    assign dma.rsp   = done && (done_peer == peer_dma);
    assign dma.rdata = done_data;

endmodule

`default_nettype wire

// File: hdl/store_lane_align.sv
// ##############################
// Misaligned addresses act as their naturally aligned address
// ##############################
`timescale 1ns/100ps
`default_nettype none

module store_lane_align import mem_pkg::*; (
    input  logic       issue,
    input  logic       issue_we,
    input  width_e     issue_width,
    input  byte_addr_t issue_addr,
    input  data_t      issue_wdata,
    ram_if.master      ram
);

    lane_off_t  offset;
    byte_mask_t base_mask;

    assign offset = align_offset(issue_width, issue_addr);

    always_comb begin
        case (issue_width)
            width_8:  base_mask = 8'h01;
            width_16: base_mask = 8'h03;
            width_32: base_mask = 8'h0f;
            default:  base_mask = 8'hff;
        endcase
    end

    // ##############################
    // RAM request
    // ##############################
    assign ram.en        = issue;
    assign ram.we        = issue_we;
    assign ram.word_addr = issue_addr[BYTE_ADDR_W-1:LANE_OFF_W];  // Drop the lane bits
    assign ram.byte_mask = base_mask << offset;
    assign ram.wdata     = issue_wdata << {offset, 3'b000};       // Low bytes move up to their lanes

endmodule

`default_nettype wire

// File: hdl/data_ram.sv
// ##############################
// Single port, so a cycle is either a read or a write
// ##############################
`timescale 1ns/100ps
`default_nettype none

module data_ram import mem_pkg::*; (
    input  logic  clk,
    ram_if.slave  ram
);

    data_t mem [RAM_WORDS];

    // Byte-lane write
    always_ff @(posedge clk) begin
        if (ram.en && ram.we) begin
            for (int i = 0; i < LANES; i++) begin
                if (ram.byte_mask[i]) begin
                    mem[ram.word_addr][8*i +: 8] <= ram.wdata[8*i +: 8];
                end
            end
        end
    end

    // Registered read that holds its word until the next read
    always_ff @(posedge clk) begin
        if (ram.en && !ram.we) begin
            ram.rdata <= mem[ram.word_addr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/load_extract.sv
// ##############################
// Response comes one cycle after issue and is zero-extended
// ##############################
`timescale 1ns/100ps
`default_nettype none

module load_extract import mem_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       issue,
    input  logic       issue_we,
    input  width_e     issue_width,
    input  byte_addr_t issue_addr,
    input  peer_e      issue_peer,
    ram_if.reader      ram,
    output logic       done,
    output peer_e      done_peer,
    output data_t      done_data
);

    logic      rsp_valid;
    logic      rsp_we;
    width_e    rsp_width;
    lane_off_t rsp_off;
    peer_e     rsp_peer;
    data_t     lanes;

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            rsp_we    <= issue_we;
            rsp_width <= issue_width;
            rsp_off   <= align_offset(issue_width, issue_addr);
            rsp_peer  <= issue_peer;
        end
    end

    // ##############################
    // Lane pick
    // ##############################
    assign lanes = ram.rdata >> {rsp_off, 3'b000};        // Addressed lane moves to bit 0

    always_comb begin
        case (rsp_width)
            width_8:  done_data = data_t'(lanes[7:0]);
            width_16: done_data = data_t'(lanes[15:0]);
            width_32: done_data = data_t'(lanes[31:0]);
            default:  done_data = lanes;
        endcase
        if (rsp_we) begin
            done_data = '0;                               // Writes return zero
        end
    end

    assign done      = rsp_valid;
    assign done_peer = rsp_peer;

endmodule

`default_nettype wire

// File: hdl/mem_system.sv
// ##############################
// Each port waits for rsp before its next req; one or two cycles of latency
// ##############################
`timescale 1ns/100ps
`default_nettype none

module mem_system import mem_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       cpu_req,
    input  logic       cpu_we,
    input  width_e     cpu_width,
    input  byte_addr_t cpu_addr,
    input  data_t      cpu_wdata,
    output logic       cpu_rsp,
    output data_t      cpu_rdata,
    input  logic       dma_req,
    input  logic       dma_we,
    input  width_e     dma_width,
    input  byte_addr_t dma_addr,
    input  data_t      dma_wdata,
    output logic       dma_rsp,
    output data_t      dma_rdata
);

    mem_port_if cpu_if ();
    mem_port_if dma_if ();
    ram_if      ram_bus ();

    logic       issue;
    logic       issue_we;
    width_e     issue_width;
    byte_addr_t issue_addr;
    data_t      issue_wdata;
    peer_e      issue_peer;
    logic       done;
    peer_e      done_peer;
    data_t      done_data;

    // ##############################
    // Ports onto the requester buses
    // ##############################
    assign cpu_if.req   = cpu_req;
    assign cpu_if.we    = cpu_we;
    assign cpu_if.width = cpu_width;
    assign cpu_if.addr  = cpu_addr;
    assign cpu_if.wdata = cpu_wdata;
    assign cpu_rsp      = cpu_if.rsp;
    assign cpu_rdata    = cpu_if.rdata;

    assign dma_if.req   = dma_req;
    assign dma_if.we    = dma_we;
    assign dma_if.width = dma_width;
    assign dma_if.addr  = dma_addr;
    assign dma_if.wdata = dma_wdata;
    assign dma_rsp      = dma_if.rsp;
    assign dma_rdata    = dma_if.rdata;

    mem_arbiter u_mem_arbiter (
        .clk(clk), .reset(reset), .cpu(cpu_if.target), .dma(dma_if.target),
        .issue(issue), .issue_we(issue_we), .issue_width(issue_width),
        .issue_addr(issue_addr), .issue_wdata(issue_wdata), .issue_peer(issue_peer),
        .done(done), .done_peer(done_peer), .done_data(done_data)
    );

    store_lane_align u_store_lane_align (
        .issue(issue), .issue_we(issue_we), .issue_width(issue_width),
        .issue_addr(issue_addr), .issue_wdata(issue_wdata), .ram(ram_bus.master)
    );

    data_ram u_data_ram (.clk(clk), .ram(ram_bus.slave));

    load_extract u_load_extract (
        .clk(clk), .reset(reset), .issue(issue), .issue_we(issue_we),
        .issue_width(issue_width), .issue_addr(issue_addr), .issue_peer(issue_peer),
        .ram(ram_bus.reader), .done(done), .done_peer(done_peer), .done_data(done_data)
    );

endmodule

`default_nettype wire

// File: tb/mem_system_tb.sv
// ##############################
// Reads only touch words that the tests wrote first, since the RAM starts unknown
// CPU and DMA random traffic use disjoint words so the shadow order stays exact
// ##############################
`timescale 1ns/100ps
`default_nettype none

module mem_system_tb import mem_pkg::*; ();

    localparam int FILL_WORDS    = 16;
    localparam int CONT_ROUNDS   = 8;
    localparam int RAND_PER_PEER = 150;
    localparam int TOTAL_REQS    = FILL_WORDS * 15 + 9 + CONT_ROUNDS * 4 + RAND_PER_PEER * 2;
    localparam int CYCLE_LIMIT   = 20 * TOTAL_REQS + 100;

    logic       clk;
    logic       reset;
    logic       cpu_req, cpu_we, dma_req, dma_we;
    width_e     cpu_width, dma_width;
    byte_addr_t cpu_addr, dma_addr;
    data_t      cpu_wdata, dma_wdata;
    logic       cpu_rsp, dma_rsp;
    data_t      cpu_rdata, dma_rdata;

    logic [7:0]  shadow [RAM_WORDS * LANES];              // Byte image of the RAM
    data_t       cpu_exp_q[$];
    data_t       dma_exp_q[$];
    int          req_cycle [2];
    int          rsp_count [2];
    int          cycle  = 0;
    int          checks = 0;
    int          errors = 0;
    int unsigned lcg_state = 18932;

    logic       rnd_we    [2][RAND_PER_PEER];
    width_e     rnd_width [2][RAND_PER_PEER];
    byte_addr_t rnd_addr  [2][RAND_PER_PEER];
    data_t      rnd_data  [2][RAND_PER_PEER];

    mem_system u_mem_system (
        .clk(clk), .reset(reset),
        .cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_width(cpu_width), .cpu_addr(cpu_addr),
        .cpu_wdata(cpu_wdata), .cpu_rsp(cpu_rsp), .cpu_rdata(cpu_rdata),
        .dma_req(dma_req), .dma_we(dma_we), .dma_width(dma_width), .dma_addr(dma_addr),
        .dma_wdata(dma_wdata), .dma_rsp(dma_rsp), .dma_rdata(dma_rdata)
    );

    always #2 clk = ~clk;

    // ##############################
    // Reference model
    // ##############################
    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;                            // Low bits of an LCG repeat quickly
    endfunction

    function automatic data_t ref_load(input byte_addr_t addr, input width_e width);
        int         size;
        byte_addr_t base;
        data_t      val;
        size = 1 << width;
        base = addr & ~byte_addr_t'(size - 1);            // Natural alignment
        val  = '0;
        for (int i = 0; i < size; i++) begin
            val[8*i +: 8] = shadow[base + i];
        end
        return val;
    endfunction

    task automatic store_shadow(input byte_addr_t addr, input width_e width, input data_t data);
        int         size;
        byte_addr_t base;
        size = 1 << width;
        base = addr & ~byte_addr_t'(size - 1);
        for (int i = 0; i < size; i++) begin
            shadow[base + i] = data[8*i +: 8];            // Low bytes of the data land here
        end
    endtask

    task automatic check_value(input data_t got, input data_t expected, input string what);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail at %0d ns: %s got %h expected %h", $time, what, got, expected);
        end
    endtask

    // ##############################
    // Driving and comparing
    // ##############################
    task automatic access(input peer_e p, input logic we, input width_e width,
                          input byte_addr_t addr, input data_t wdata);
        data_t expected;
        int    target;
        if (we) begin
            store_shadow(addr, width, wdata);
            expected = '0;                                // Write responses carry zero
        end else begin
            expected = ref_load(addr, width);
        end
        @(posedge clk);
        #0.5;
        req_cycle[p] = cycle;
        target       = rsp_count[p] + 1;
        if (p == peer_cpu) begin
            cpu_exp_q.push_back(expected);
            cpu_req   = 1'b1;
            cpu_we    = we;
            cpu_width = width;
            cpu_addr  = addr;
            cpu_wdata = wdata;
        end else begin
            dma_exp_q.push_back(expected);
            dma_req   = 1'b1;
            dma_we    = we;
            dma_width = width;
            dma_addr  = addr;
            dma_wdata = wdata;
        end
        @(posedge clk);
        #0.5;
        if (p == peer_cpu) begin
            cpu_req = 1'b0;
        end else begin
            dma_req = 1'b0;
        end
        wait (rsp_count[p] >= target);
    endtask

    task automatic take_response(input peer_e p, input data_t got);
        data_t expected;
        int    lat;
        if ((p == peer_cpu) ? (cpu_exp_q.size() == 0) : (dma_exp_q.size() == 0)) begin
            errors++;
            $display("Error at %0d ns: response on the %s port with nothing outstanding",
                     $time, p.name());
            return;
        end
        expected = (p == peer_cpu) ? cpu_exp_q.pop_front() : dma_exp_q.pop_front();
        lat      = cycle - req_cycle[p];
        check_value(got, expected, {p.name(), " rdata"});
        check_value((lat == 1) || (lat == 2), 1'b1, {p.name(), " latency of one or two cycles"});
        rsp_count[p]++;
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (cpu_rsp) begin
                take_response(peer_cpu, cpu_rdata);
            end
            if (dma_rsp) begin
                take_response(peer_dma, dma_rdata);
            end
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: the run passed %0d cycles without finishing", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic run_random(input peer_e p);
        for (int i = 0; i < RAND_PER_PEER; i++) begin
            access(p, rnd_we[p][i], rnd_width[p][i], rnd_addr[p][i], rnd_data[p][i]);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("%s finished with %0d errors", name, errors - err_start);
    endtask

    // ##############################
    // Test sequence
    // ##############################
    initial begin
        int err_start;
        clk       = 1'b0;
        reset     = 1'b1;
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_width = width_8;
        cpu_addr  = '0;
        cpu_wdata = '0;
        dma_req   = 1'b0;
        dma_we    = 1'b0;
        dma_width = width_8;
        dma_addr  = '0;
        dma_wdata = '0;
        rsp_count = '{0, 0};
        req_cycle = '{0, 0};
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < RAND_PER_PEER; i++) begin
                rnd_we[p][i]    = next_random() % 2;
                rnd_width[p][i] = width_e'(next_random() % 4);
                rnd_addr[p][i]  = byte_addr_t'(p * 64 + next_random() % 64);  // 8 words per peer
                rnd_data[p][i]  = {next_random(), next_random()};
            end
        end
        repeat (5) @(posedge clk);
        #0.5;
        reset = 1'b0;

        err_start = errors;                               // Idle ports after reset
        repeat (10) begin
            @(negedge clk);
            check_value(cpu_rsp, 1'b0, "cpu_rsp while idle");
            check_value(dma_rsp, 1'b0, "dma_rsp while idle");
        end
        report_test("Reset state", err_start);

        err_start = errors;
        for (int w = 0; w < FILL_WORDS; w++) begin
            access(peer_cpu, 1'b1, width_64, byte_addr_t'(w * 8), {next_random(), next_random()});
        end
        for (int w = 0; w < FILL_WORDS; w++) begin
            for (int off = 0; off < 8; off++) begin
                access(peer_cpu, 1'b0, width_8, byte_addr_t'(w * 8 + off), '0);
            end
            for (int off = 0; off < 8; off += 2) begin
                access(peer_cpu, 1'b0, width_16, byte_addr_t'(w * 8 + off), '0);
            end
            for (int off = 0; off < 8; off += 4) begin
                access(peer_cpu, 1'b0, width_32, byte_addr_t'(w * 8 + off), '0);
            end
        end
        report_test("Width round trip", err_start);

        err_start = errors;                               // Word 20 with junk in the upper data bits
        access(peer_cpu, 1'b1, width_64, 16'd160, 64'h0123_4567_89ab_cdef);
        access(peer_cpu, 1'b1, width_8, 16'd161, 64'hdead_beef_0000_005a);
        access(peer_cpu, 1'b0, width_64, 16'd160, '0);
        access(peer_cpu, 1'b1, width_16, 16'd163, 64'hffff_ffff_ffff_beef);
        access(peer_cpu, 1'b0, width_64, 16'd160, '0);
        access(peer_cpu, 1'b1, width_32, 16'd165, 64'haaaa_aaaa_1234_5678);
        access(peer_cpu, 1'b0, width_64, 16'd160, '0);
        access(peer_cpu, 1'b1, width_8, 16'd167, 64'h5555_5555_5555_55c3);
        access(peer_cpu, 1'b0, width_64, 16'd166, '0);
        report_test("Byte-masked stores", err_start);

        err_start = errors;
        for (int r = 0; r < CONT_ROUNDS; r++) begin
            fork
                access(peer_cpu, 1'b1, width_64, byte_addr_t'((32 + r) * 8),
                       {next_random(), 32'h0000_c0de});
                access(peer_dma, 1'b1, width_64, byte_addr_t'((48 + r) * 8),
                       {next_random(), 32'h0000_d3a0});
            join
            fork
                access(peer_cpu, 1'b0, width_64, byte_addr_t'((32 + r) * 8), '0);
                access(peer_dma, 1'b0, width_64, byte_addr_t'((48 + r) * 8), '0);
            join
        end
        report_test("Contention", err_start);

        err_start = errors;
        fork
            run_random(peer_cpu);
            run_random(peer_dma);
        join
        report_test("Random mixed traffic", err_start);

        $display("Totals: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mem_system.f
hdl/mem_pkg.sv
hdl/mem_ifs.sv
hdl/mem_arbiter.sv
hdl/store_lane_align.sv
hdl/data_ram.sv
hdl/load_extract.sv
hdl/mem_system.sv
tb/mem_system_tb.sv
